//--- common/rv_pkg.sv
package rv_pkg;

    parameter int XLEN = 64;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [31:0]     instr_t;
    typedef logic [4:0]      reg_idx_t;
    typedef logic [11:0]     csr_addr_t;
    typedef logic [1:0]      priv_t;

    // Major opcodes of the RV64I base set that decode cares about.
    parameter logic [6:0] OP_LOAD   = 7'b0000011;
    parameter logic [6:0] OP_STORE  = 7'b0100011;
    parameter logic [6:0] OP_BRANCH = 7'b1100011;
    parameter logic [6:0] OP_JALR   = 7'b1100111;
    parameter logic [6:0] OP_LUI    = 7'b0110111;
    parameter logic [6:0] OP_AUIPC  = 7'b0010111;
    parameter logic [6:0] OP_IMM    = 7'b0010011;
    parameter logic [6:0] OP_IMM32  = 7'b0011011;
    parameter logic [6:0] OP_SYSTEM = 7'b1110011;

    parameter csr_addr_t CSR_MSTATUS  = 12'h300;
    parameter csr_addr_t CSR_MTVEC    = 12'h305;
    parameter csr_addr_t CSR_MSCRATCH = 12'h340;
    parameter csr_addr_t CSR_MEPC     = 12'h341;
    parameter csr_addr_t CSR_MCAUSE   = 12'h342;

    parameter priv_t PRIV_M = 2'd3;

    typedef struct packed {
        reg_idx_t  rd;
        xlen_t     rf_data;
        logic      rf_we;
        csr_addr_t csr_addr;
        xlen_t     csr_data;
        logic      csr_we;
        logic      trap;
        xlen_t     cause;
        xlen_t     trap_pc;
    } wb_bus_t;

    typedef struct packed {
        instr_t exe_ir;
        instr_t mem_ir;
        xlen_t  mem_alu_result;
        xlen_t  wb_alu_result;
        xlen_t  wb_mem_result;
    } fwd_bus_t;

    typedef struct packed {
        logic   valid;
        xlen_t  npc;
        instr_t ir;
        xlen_t  alu_one;
        xlen_t  alu_two;
        xlen_t  store_data;
        xlen_t  csr_rdata;
        logic   ecall;
    } exe_bus_t;

endpackage

//--- decode/register_file.sv
module register_file (
    input  logic             CLK,
    input  logic             RESET,
    input  rv_pkg::reg_idx_t rs1,
    input  rv_pkg::reg_idx_t rs2,
    input  rv_pkg::reg_idx_t rd,
    input  rv_pkg::xlen_t    wdata,
    input  logic             we,
    output rv_pkg::xlen_t    rdata1,
    output rv_pkg::xlen_t    rdata2
);

    import rv_pkg::*;

    // There is no storage for x0.
    xlen_t regs [1:31];

    always_ff @(posedge CLK) begin
        if (RESET) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd != '0)) begin
            regs[rd] <= wdata;
        end
    end

    // A read in the same cycle as a write to that register returns the old value.
    always_comb begin
        if (rs1 == '0) begin
            rdata1 = '0;
        end else begin
            rdata1 = regs[rs1];
        end
        if (rs2 == '0) begin
            rdata2 = '0;
        end else begin
            rdata2 = regs[rs2];
        end
    end

    write_then_read_a: assert property (
        @(posedge CLK) disable iff (RESET)
        (we && (rd != '0)) |=> ((rs1 != $past(rd)) || (rdata1 == $past(wdata)))
    );

endmodule

//--- decode/csr_file.sv
module csr_file #(
    parameter rv_pkg::xlen_t MTVEC_RESET = 64'h100
) (
    input  logic              CLK,
    input  logic              RESET,
    input  rv_pkg::csr_addr_t raddr,
    output rv_pkg::xlen_t     rdata,
    input  rv_pkg::wb_bus_t   wb,
    output rv_pkg::xlen_t     mtvec,
    output rv_pkg::priv_t     privilege
);

    import rv_pkg::*;

    xlen_t mstatus_q;
    xlen_t mtvec_q;
    xlen_t mepc_q;
    xlen_t mcause_q;
    xlen_t mscratch_q;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            mstatus_q  <= '0;
            mtvec_q    <= MTVEC_RESET;
            mepc_q     <= '0;
            mcause_q   <= '0;
            mscratch_q <= '0;
        end else if (wb.trap) begin
            // Trap entry wins over any CSR write arriving in the same cycle.
            mcause_q          <= wb.cause;
            mepc_q            <= wb.trap_pc;
            mstatus_q[12:11]  <= PRIV_M;
            mstatus_q[7]      <= mstatus_q[3];
            mstatus_q[3]      <= 1'b0;
        end else if (wb.csr_we) begin
            case (wb.csr_addr)
                CSR_MSTATUS:  mstatus_q  <= wb.csr_data;
                CSR_MTVEC:    mtvec_q    <= wb.csr_data;
                CSR_MEPC:     mepc_q     <= wb.csr_data;
                CSR_MCAUSE:   mcause_q   <= wb.csr_data;
                CSR_MSCRATCH: mscratch_q <= wb.csr_data;
                default:      ;
            endcase
        end
    end

    always_comb begin
        case (raddr)
            CSR_MSTATUS:  rdata = mstatus_q;
            CSR_MTVEC:    rdata = mtvec_q;
            CSR_MEPC:     rdata = mepc_q;
            CSR_MCAUSE:   rdata = mcause_q;
            CSR_MSCRATCH: rdata = mscratch_q;
            default:      rdata = '0;
        endcase
    end

    // Only machine mode is implemented.
    assign mtvec     = mtvec_q;
    assign privilege = PRIV_M;

    trap_drops_csr_write_a: assert property (
        @(posedge CLK) disable iff (RESET)
        (wb.trap && wb.csr_we) |=> ($stable(mtvec_q) && $stable(mscratch_q))
    );

endmodule

//--- decode/imm_gen.sv
module imm_gen (
    input  rv_pkg::instr_t ir,
    output rv_pkg::xlen_t  imm
);

    import rv_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    xlen_t      imm_i;
    xlen_t      imm_s;
    xlen_t      imm_b;
    xlen_t      imm_u;

    assign opcode = ir[6:0];
    assign funct3 = ir[14:12];

    assign imm_i = {{52{ir[31]}}, ir[31:20]};
    assign imm_s = {{52{ir[31]}}, ir[31:25], ir[11:7]};
    assign imm_b = {{51{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
    assign imm_u = {{32{ir[31]}}, ir[31:12], 12'd0};

    always_comb begin
        case (opcode)
            OP_LOAD, OP_JALR: imm = imm_i;
            OP_STORE:         imm = imm_s;
            OP_BRANCH:        imm = imm_b;
            OP_LUI, OP_AUIPC: imm = imm_u;
            OP_IMM: begin
                // SLLI, SRLI and SRAI carry a 6-bit shamt.
                if (funct3[1:0] == 2'b01) begin
                    imm = {58'd0, ir[25:20]};
                end else begin
                    imm = imm_i;
                end
            end
            OP_IMM32: begin
                if (funct3[1:0] == 2'b01) begin
                    imm = {59'd0, ir[24:20]};
                end else begin
                    imm = imm_i;
                end
            end
            default:          imm = '0;
        endcase
    end

endmodule

//--- decode/operand_forward.sv
module operand_forward (
    input  rv_pkg::instr_t   ir,
    input  rv_pkg::fwd_bus_t fwd,
    input  rv_pkg::xlen_t    rf_rs1,
    input  rv_pkg::xlen_t    rf_rs2,
    output rv_pkg::xlen_t    op1,
    output rv_pkg::xlen_t    op2
);

    import rv_pkg::*;

    // Picks the newest in-flight result for one source register.
    function automatic xlen_t bypass(
        input reg_idx_t src,
        input xlen_t    rf_val,
        input fwd_bus_t bus
    );
        logic exe_hit;
        logic mem_hit;
        exe_hit = !bus.exe_ir[6] && (bus.exe_ir[11:7] == src) && (src != 5'd0);
        mem_hit = !bus.mem_ir[6] && (bus.mem_ir[11:7] == src) && (src != 5'd0);
        if (exe_hit && bus.exe_ir[4]) begin
            return bus.mem_alu_result;
        end else if (mem_hit && bus.mem_ir[4]) begin
            return bus.wb_alu_result;
        end else if (mem_hit) begin
            // A load in memory has its data one stage later.
            return bus.wb_mem_result;
        end
        return rf_val;
    endfunction

    assign op1 = bypass(ir[19:15], rf_rs1, fwd);
    assign op2 = bypass(ir[24:20], rf_rs2, fwd);

endmodule

//--- decode/decode_stage.sv
module decode_stage #(
    parameter rv_pkg::xlen_t MTVEC_RESET = 64'h100
) (
    input  logic             CLK,
    input  logic             RESET,
    input  rv_pkg::instr_t   de_ir,
    input  rv_pkg::xlen_t    de_npc,
    input  logic             de_valid,
    input  logic             mem_stall,
    input  rv_pkg::fwd_bus_t fwd,
    input  rv_pkg::wb_bus_t  wb,
    output rv_pkg::exe_bus_t exe,
    output logic             br_stall,
    output logic             csr_access,
    output rv_pkg::xlen_t    mtvec,
    output rv_pkg::priv_t    privilege
);

    import rv_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    xlen_t      rf_rdata1;
    xlen_t      rf_rdata2;
    xlen_t      csr_rdata;
    xlen_t      imm;
    xlen_t      op1;
    xlen_t      op2;
    exe_bus_t   exe_next;
    logic       load_exe;

    assign opcode = de_ir[6:0];
    assign funct3 = de_ir[14:12];
    assign rs1    = de_ir[19:15];
    assign rs2    = de_ir[24:20];

    register_file rf_i (
        .CLK    (CLK),
        .RESET  (RESET),
        .rs1    (rs1),
        .rs2    (rs2),
        .rd     (wb.rd),
        .wdata  (wb.rf_data),
        .we     (wb.rf_we),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2)
    );

    csr_file #(
        .MTVEC_RESET (MTVEC_RESET)
    ) csr_i (
        .CLK       (CLK),
        .RESET     (RESET),
        .raddr     (de_ir[31:20]),
        .rdata     (csr_rdata),
        .wb        (wb),
        .mtvec     (mtvec),
        .privilege (privilege)
    );

    imm_gen imm_i (
        .ir  (de_ir),
        .imm (imm)
    );

    operand_forward fwd_i (
        .ir     (de_ir),
        .fwd    (fwd),
        .rf_rs1 (rf_rdata1),
        .rf_rs2 (rf_rdata2),
        .op1    (op1),
        .op2    (op2)
    );

    always_comb begin
        exe_next.valid = 1'b1;
        exe_next.npc   = de_npc;
        exe_next.ir    = de_ir;
        // CSRRWI, CSRRSI and CSRRCI take the rs1 field as a zimm.
        if ((opcode == OP_SYSTEM) && funct3[2]) begin
            exe_next.alu_one = {59'd0, rs1};
        end else begin
            exe_next.alu_one = op1;
        end
        if (de_ir[5] && (opcode != OP_LUI)) begin
            exe_next.alu_two = op2;
        end else begin
            exe_next.alu_two = imm;
        end
        exe_next.store_data = op2;
        exe_next.csr_rdata  = csr_rdata;
        exe_next.ecall      = (de_ir == 32'h00000073);
    end

    assign load_exe   = de_valid && !mem_stall;
    assign br_stall   = de_valid && (opcode == OP_BRANCH);
    assign csr_access = de_valid && (opcode == OP_SYSTEM) && (funct3 != 3'd0);

    always_ff @(posedge CLK) begin
        if (RESET) begin
            exe <= '0;
        end else if (load_exe) begin
            exe <= exe_next;
        end
    end

    exe_holds_on_stall_a: assert property (
        @(posedge CLK) disable iff (RESET)
        mem_stall |=> $stable(exe)
    );

endmodule

//--- bench/decode_tb.sv
module decode_tb;

    import rv_pkg::*;

    localparam xlen_t MTVEC_INIT = 64'h100;
    localparam string TRACE_PATH = "bench/decode_trace.txt";

    logic     CLK;
    logic     RESET;
    instr_t   de_ir;
    xlen_t    de_npc;
    logic     de_valid;
    logic     mem_stall;
    fwd_bus_t fwd;
    wb_bus_t  wb;
    exe_bus_t exe;
    logic     br_stall;
    logic     csr_access;
    xlen_t    mtvec;
    priv_t    privilege;

    // Hex fields of the trace record being processed.
    logic [63:0] field [12];
    int          checks;

    decode_stage #(
        .MTVEC_RESET (MTVEC_INIT)
    ) dut_i (
        .CLK        (CLK),
        .RESET      (RESET),
        .de_ir      (de_ir),
        .de_npc     (de_npc),
        .de_valid   (de_valid),
        .mem_stall  (mem_stall),
        .fwd        (fwd),
        .wb         (wb),
        .exe        (exe),
        .br_stall   (br_stall),
        .csr_access (csr_access),
        .mtvec      (mtvec),
        .privilege  (privilege)
    );

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    task automatic stop_with_failure();
        $display("Simulation failed");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("[ERROR] %0t: %s is %h, expected %h", $time, what, actual, expected);
            stop_with_failure();
        end
    endtask

    task automatic wait_cycles(input int count);
        for (int i = 0; i < count; i++) begin
            @(posedge CLK);
        end
    endtask

    // The writeback is presented for one cycle and lands at the following edge.
    task automatic apply_writeback();
        @(posedge CLK);
        wb.rd       <= field[0][4:0];
        wb.rf_data  <= field[1];
        wb.rf_we    <= field[2][0];
        wb.csr_addr <= field[3][11:0];
        wb.csr_data <= field[4];
        wb.csr_we   <= field[5][0];
        wb.trap     <= field[6][0];
        wb.cause    <= field[7];
        wb.trap_pc  <= field[8];
        @(posedge CLK);
        wb <= '0;
        @(negedge CLK);
    endtask

    task automatic apply_decode();
        @(posedge CLK);
        de_valid           <= field[0][0];
        de_ir              <= field[1][31:0];
        de_npc             <= field[2];
        fwd.exe_ir         <= field[3][31:0];
        fwd.mem_ir         <= field[4][31:0];
        fwd.mem_alu_result <= field[5];
        fwd.wb_alu_result  <= field[6];
        fwd.wb_mem_result  <= field[7];
        mem_stall          <= field[8][0];
        // The exe register loads at the next edge; outputs are sampled mid-cycle.
        wait_cycles(1);
        @(negedge CLK);
    endtask

    task automatic check_outputs();
        check_value({63'd0, exe.valid}, field[0], "exe.valid");
        check_value({32'd0, exe.ir}, field[1], "exe.ir");
        check_value(exe.npc, field[2], "exe.npc");
        check_value(exe.alu_one, field[3], "exe.alu_one");
        check_value(exe.alu_two, field[4], "exe.alu_two");
        check_value(exe.store_data, field[5], "exe.store_data");
        check_value(exe.csr_rdata, field[6], "exe.csr_rdata");
        check_value({63'd0, exe.ecall}, field[7], "exe.ecall");
        check_value({63'd0, br_stall}, field[8], "br_stall");
        check_value({63'd0, csr_access}, field[9], "csr_access");
        check_value(mtvec, field[10], "mtvec");
        check_value({62'd0, privilege}, field[11], "privilege");
        checks++;
    endtask

    task automatic run_record(input string line);
        byte   kind;
        string body;
        int    n;
        kind = line.getc(0);
        body = line.substr(2, line.len() - 1);
        case (kind)
            "#", "\n", " ": begin
            end
            "W", "D": begin
                n = $sscanf(body, "%h %h %h %h %h %h %h %h %h", field[0], field[1], field[2],
                            field[3], field[4], field[5], field[6], field[7], field[8]);
                if (n != 9) begin
                    $display("Malformed trace record: %s", line);
                    stop_with_failure();
                end else if (kind == "W") begin
                    apply_writeback();
                end else begin
                    apply_decode();
                end
            end
            "E": begin
                n = $sscanf(body, "%h %h %h %h %h %h %h %h %h %h %h %h", field[0], field[1],
                            field[2], field[3], field[4], field[5], field[6], field[7],
                            field[8], field[9], field[10], field[11]);
                if (n != 12) begin
                    $display("Malformed trace record: %s", line);
                    stop_with_failure();
                end else begin
                    check_outputs();
                end
            end
            default: begin
                $display("Unknown record kind in trace line: %s", line);
                stop_with_failure();
            end
        endcase
    endtask

    initial begin
        int    fd;
        string line;
        RESET     = 1'b1;
        de_ir     = '0;
        de_npc    = '0;
        de_valid  = 1'b0;
        mem_stall = 1'b0;
        fwd       = '0;
        wb        = '0;
        checks    = 0;
        wait_cycles(10);
        RESET <= 1'b0;
        @(negedge CLK);
        fd = $fopen(TRACE_PATH, "r");
        if (fd == 0) begin
            $display("Could not open the trace file %s", TRACE_PATH);
            stop_with_failure();
        end else begin
            while ($fgets(line, fd) != 0) begin
                run_record(line);
            end
            $fclose(fd);
            if (checks == 0) begin
                $display("The trace file held no expected-value records");
                stop_with_failure();
            end else begin
                $display("Simulation completed successfully");
                $finish;
            end
        end
    end

endmodule

//--- bench/decode_trace.txt
# W rd rf_data rf_we csr_addr csr_data csr_we trap cause trap_pc
# D valid ir npc exe_ir mem_ir mem_alu_result wb_alu_result wb_mem_result mem_stall
# E valid ir npc alu_one alu_two store_data csr_rdata ecall br_stall csr_access mtvec privilege
E 0 00000000 0 0 0 0 0 0 0 0 100 3
W 05 1122334455667788 1 000 0 0 0 0 0
W 00 00000000deadbeef 1 000 0 0 0 0 0
D 1 ffc28313 1000 00000000 00000000 0 0 0 0
E 1 ffc28313 1000 1122334455667788 fffffffffffffffc 0 0 0 0 0 100 3
D 1 12300393 1004 00000000 00000000 0 0 0 0
E 1 12300393 1004 0 123 0 0 0 0 0 100 3
# Store, branch, LUI, SRAI, SLLIW, JALR and ECALL.
D 1 fe503823 1008 00000000 00000000 0 0 0 0
E 1 fe503823 1008 0 1122334455667788 1122334455667788 0 0 0 0 100 3
D 1 fe028ce3 100c 00000000 00000000 0 0 0 0
E 1 fe028ce3 100c 1122334455667788 0 0 0 0 1 0 100 3
D 1 80001437 1010 00000000 00000000 0 0 0 0
E 1 80001437 1010 0 ffffffff80001000 0 0 0 0 0 100 3
D 1 42d2d493 1014 00000000 00000000 0 0 0 0
E 1 42d2d493 1014 1122334455667788 2d 0 0 0 0 0 100 3
D 1 03f2951b 1018 00000000 00000000 0 0 0 0
E 1 03f2951b 1018 1122334455667788 1f 0 0 0 0 0 100 3
D 1 7e5280e7 101c 00000000 00000000 0 0 0 0
E 1 7e5280e7 101c 1122334455667788 1122334455667788 1122334455667788 0 0 0 0 100 3
D 1 00000073 1020 00000000 00000000 0 0 0 0
E 1 00000073 1020 0 0 0 0 1 0 0 100 3
# Forwarding into ADD x11, x12, x13.
D 1 00d605b3 1100 00000613 00000613 a0a0a0a0a0a0a0a1 b0b0b0b0b0b0b0b2 c0c0c0c0c0c0c0c3 0
E 1 00d605b3 1100 a0a0a0a0a0a0a0a1 0 0 0 0 0 0 100 3
D 1 00d605b3 1104 00000693 00000613 a0a0a0a0a0a0a0a1 b0b0b0b0b0b0b0b2 c0c0c0c0c0c0c0c3 0
E 1 00d605b3 1104 b0b0b0b0b0b0b0b2 a0a0a0a0a0a0a0a1 a0a0a0a0a0a0a0a1 0 0 0 0 100 3
D 1 00d605b3 1108 00000000 00000603 a0a0a0a0a0a0a0a1 b0b0b0b0b0b0b0b2 c0c0c0c0c0c0c0c3 0
E 1 00d605b3 1108 c0c0c0c0c0c0c0c3 0 0 0 0 0 0 100 3
D 1 000005b3 110c 00000013 00000003 a0a0a0a0a0a0a0a1 b0b0b0b0b0b0b0b2 c0c0c0c0c0c0c0c3 0
E 1 000005b3 110c 0 0 0 0 0 0 0 100 3
D 1 00d605b3 1110 00000663 00000000 a0a0a0a0a0a0a0a1 b0b0b0b0b0b0b0b2 c0c0c0c0c0c0c0c3 0
E 1 00d605b3 1110 0 0 0 0 0 0 0 100 3
# Stall hold, then the load after the stall drops.
D 1 ffc28313 2000 00000000 00000000 0 0 0 1
E 1 00d605b3 1110 0 0 0 0 0 0 0 100 3
D 1 ffc28313 2000 00000000 00000000 0 0 0 0
E 1 ffc28313 2000 1122334455667788 fffffffffffffffc 0 0 0 0 0 100 3
# CSR path.
W 00 0 0 340 0123456789abcdef 1 0 0 0
D 1 34002773 3000 00000000 00000000 0 0 0 0
E 1 34002773 3000 0 0 0 0123456789abcdef 0 0 1 100 3
W 00 0 0 340 000000000000ffff 1 1 000000000000000b 0000000080000010
D 1 34202773 3004 00000000 00000000 0 0 0 0
E 1 34202773 3004 0 0 0 000000000000000b 0 0 1 100 3
D 1 34102773 3008 00000000 00000000 0 0 0 0
E 1 34102773 3008 0 0 0 0000000080000010 0 0 1 100 3
D 1 340ad073 300c 00000000 00000000 0 0 0 0
E 1 340ad073 300c 15 0 0 0123456789abcdef 0 0 1 100 3
W 00 0 0 305 0000000000002000 1 0 0 0
E 1 340ad073 300c 15 0 0 0123456789abcdef 0 0 1 2000 3

//--- project.f
common/rv_pkg.sv
decode/register_file.sv
decode/csr_file.sv
decode/imm_gen.sv
decode/operand_forward.sv
decode/decode_stage.sv
bench/decode_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module decode_tb -f project.f -o Vdecode_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vdecode_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation completed successfully" "$LOG"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi
